//--- all.f
+incdir+source
source/cam_fb_pkg.sv
source/wb_status_regs.sv
source/cam_word_packer.sv
source/frame_buffer.sv
source/qspi_burst_writer.sv
source/cam_fb_top.sv
dv/cam_fb_assert.sv
dv/cam_fb_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the cam_fb testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps -f all.f \
	--top-module cam_fb_tb -Mdir obj_dir -o cam_fb_sim
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

./obj_dir/cam_fb_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
	echo "Simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Test failed" sim.log; then
	exit 1
fi
exit 0

//--- dv/cam_fb_tb.sv
`timescale 1ns/1ps
`include "cam_fb_consts.svh"

module cam_fb_tb;

	localparam int total_bursts  = 16;                         // Four banks of four bursts
	localparam int pre_words     = `FB_BANK_WORDS + 88;        // Camera is past bank 0
	localparam int burst_cycles  = 8 + 6 + 8 * `QSPI_BURST_WORDS;
	localparam int timeout_cycles = 4 * 2048 * 4 * 2 + 8192;   // Run length plus margin

	logic                  WBs_CLK_i = 1'b0;
	logic                  WBs_RST_i;
	logic                  wbs_status_cyc_i;
	logic                  wbs_stb_i;
	logic                  wbs_we_i;
	cam_fb_pkg::fb_word_t  wbs_dat_i;
	logic                  wbs_ack_o;
	cam_fb_pkg::fb_word_t  wbs_status_dat_o;
	logic                  cam_vsync_i;
	logic                  cam_href_i;
	cam_fb_pkg::cam_byte_t cam_dat_i;
	logic                  qspi_ce_n_o;
	logic [3:0]            qspi_dat_o;

	logic [31:0]           lfsr = 32'hfa7f;  // Stimulus seed
	cam_fb_pkg::cam_byte_t byte_q [$];       // Bytes of the word being built
	cam_fb_pkg::fb_word_t  model_words [$];  // Every packed word in order
	int                    words_done;       // Words complete at drive time
	int                    words_d1;
	int                    words_d2;         // Lines up with the DUT bank bit
	int                    bursts_done;
	logic                  mode_written;

	always #5 WBs_CLK_i = ~WBs_CLK_i;        // 10 ns period

	cam_fb_top u_dut (.*);

	// --------------------
	// Helpers
	// --------------------
	function automatic logic lfsr_next_bit();
		logic b;
		b    = lfsr[0];
		lfsr = {1'b0, lfsr[31:1]};
		if (b)
			lfsr = lfsr ^ 32'h80200003;        // Taps 32, 22, 2, 1
		return b;
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic compare_values(input string name, input logic [31:0] exp,
		input logic [31:0] act);
		if (exp !== act) begin
			$display("mismatch %s expected %h actual %h", name, exp, act);
			$display("Test failed");
			$fatal(1, "stopping at first error");
		end
	endtask

	// One Wishbone access, read data checked against the model
	task automatic wb_cycle(input logic we, input logic [31:0] wdat, input string name);
		int          cycles;
		logic [31:0] exp;
		@(posedge WBs_CLK_i);
		wbs_status_cyc_i <= 1'b1;
		wbs_stb_i        <= 1'b1;
		wbs_we_i         <= we;
		wbs_dat_i        <= wdat;
		cycles = 0;
		do begin
			@(negedge WBs_CLK_i);
			cycles++;
			if (cycles > 16)
				abort_run("Wishbone access got no acknowledge");
		end while (!wbs_ack_o);
		compare_values({name, "_ack_delay"}, 32'd2, 32'(cycles)); // Ack one cycle after stb
		if (!we) begin
			exp                    = '0;
			exp[`STATUS_VSYNC_BIT] = cam_vsync_i;
			exp[0]                 = ((words_d2 / `FB_BANK_WORDS) % 2) != 0;
			compare_values(name, exp, wbs_status_dat_o);
		end
		@(posedge WBs_CLK_i);
		wbs_status_cyc_i <= 1'b0;
		wbs_stb_i        <= 1'b0;
		wbs_we_i         <= 1'b0;
		@(negedge WBs_CLK_i);
		compare_values({name, "_ack_width"}, 32'd0, 32'(wbs_ack_o));
	endtask

	// Sample one burst from the CE fall, k counts bursts over the run
	task automatic capture_burst(input int k);
		logic [3:0]  nib [burst_cycles];
		logic [7:0]  cmd;
		logic [23:0] addr;
		logic [31:0] word;
		int          idx;
		cmd = `QSPI_CMD_WRITE;
		if (!mode_written)
			abort_run("QSPI chip enable fell before the host enabled the drain");
		if (words_d2 < (k / 4 + 1) * `FB_BANK_WORDS)
			abort_run("QSPI burst began before the camera left the bank");
		for (int i = 0; i < burst_cycles; i++) begin
			if (i > 0)
				@(negedge WBs_CLK_i);
			if (qspi_ce_n_o)
				abort_run("QSPI chip enable rose in the middle of a burst");
			nib[i] = qspi_dat_o;
		end
		for (int i = 0; i < 8; i++)
			compare_values("burst_cmd", 32'({3'b000, cmd[7-i]}), 32'(nib[i])); // DQ0 only
		addr = '0;
		for (int i = 0; i < 6; i++)
			addr = {addr[19:0], nib[8+i]};
		compare_values("burst_addr",
			32'(24'(`QSPI_START_ADDR + k * `QSPI_BURST_BYTES)), 32'(addr));
		for (int w = 0; w < `QSPI_BURST_WORDS; w++) begin
			word = '0;
			for (int n = 0; n < 8; n++)
				word = {word[27:0], nib[14 + 8*w + n]};
			idx = k * `QSPI_BURST_WORDS + w;
			if (idx >= model_words.size())
				abort_run("QSPI burst carried a word the camera never sent");
			compare_values("burst_data", model_words[idx], word);
		end
		repeat (2) begin
			@(negedge WBs_CLK_i);
			compare_values("ce_gap", 32'd1, 32'(qspi_ce_n_o));
		end
	endtask

	// --------------------
	// Camera source and model
	// --------------------
	always @(posedge WBs_CLK_i) begin : drive_cam
		logic                  href_b;
		logic                  vsync_b;
		cam_fb_pkg::cam_byte_t dat_b;
		if (!WBs_RST_i) begin
			words_d2 = words_d1;               // DUT bank moves two edges after drive
			words_d1 = words_done;
			href_b   = lfsr_next_bit();
			vsync_b  = lfsr_next_bit();
			dat_b    = '0;
			for (int i = 0; i < `CAM_BYTE_W; i++)
				dat_b = {dat_b[6:0], lfsr_next_bit()};
			cam_href_i  <= href_b;
			cam_vsync_i <= vsync_b;
			cam_dat_i   <= dat_b;
			if (href_b && vsync_b) begin
				byte_q.push_back(dat_b);
				if (byte_q.size() == 4) begin
					model_words.push_back({byte_q[0], byte_q[1], byte_q[2], byte_q[3]});
					byte_q.delete();
					words_done++;
				end
			end
		end
	end

	initial begin : qspi_monitor
		while (bursts_done < total_bursts) begin
			@(negedge WBs_CLK_i);
			if (WBs_RST_i === 1'b0 && qspi_ce_n_o === 1'b0) begin
				capture_burst(bursts_done);
				bursts_done++;
			end
		end
	end

	initial begin : watchdog
		#(timeout_cycles * 10);
		abort_run("Simulation timed out before all banks were drained to the QSPI SRAM");
	end

	// --------------------
	// Main sequence
	// --------------------
	initial begin : main
		WBs_RST_i        = 1'b1;
		wbs_status_cyc_i = 1'b0;
		wbs_stb_i        = 1'b0;
		wbs_we_i         = 1'b0;
		wbs_dat_i        = '0;
		cam_href_i       = 1'b0;
		cam_vsync_i      = 1'b1;               // Shows up in the status word
		cam_dat_i        = '0;
		words_done       = 0;
		words_d1         = 0;
		words_d2         = 0;
		bursts_done      = 0;
		mode_written     = 1'b0;
		repeat (5) begin
			@(negedge WBs_CLK_i);
			compare_values("reset_ack", 32'd0, 32'(wbs_ack_o));
			compare_values("reset_ce_n", 32'd1, 32'(qspi_ce_n_o));
			compare_values("reset_qspi_dat", 32'd0, 32'(qspi_dat_o));
			compare_values("reset_status", 32'h100, wbs_status_dat_o);
		end
		@(posedge WBs_CLK_i);
		WBs_RST_i <= 1'b0;
		@(negedge WBs_CLK_i);
		compare_values("after_reset_ack", 32'd0, 32'(wbs_ack_o));
		compare_values("after_reset_ce_n", 32'd1, 32'(qspi_ce_n_o));
		wb_cycle(1'b0, '0, "status_after_reset");
		while (words_d2 < pre_words) begin      // No drain before the mode write
			@(negedge WBs_CLK_i);
			compare_values("ce_before_mode", 32'd1, 32'(qspi_ce_n_o));
		end
		mode_written = 1'b1;
		wb_cycle(1'b1, 32'(`STATUS_MODE_WRITE), "mode_write");
		while (bursts_done < total_bursts) begin
			repeat (397) @(posedge WBs_CLK_i);
			wb_cycle(1'b0, '0, "status_run");
		end
		$display("Test passed");
		$finish;
	end

endmodule

//--- dv/cam_fb_assert.sv
`timescale 1ns/1ps
`include "cam_fb_consts.svh"

module cam_fb_assert (
	input logic clk_i,
	input logic rst_i,
	input logic ack_i,
	input logic ce_n_i
);

	localparam int burst_cycles = 8 + 6 + 8 * `QSPI_BURST_WORDS; // Cmd, addr, data

	int low_cnt; // Consecutive cycles with CE low

	always_ff @(posedge clk_i or posedge rst_i) begin
		if (rst_i)
			low_cnt <= 0;
		else if (!ce_n_i)
			low_cnt <= low_cnt + 1;
		else
			low_cnt <= 0;
	end

	// --------------------
	// Bus and QSPI rules
	// --------------------
	ack_single: assert property (@(posedge clk_i) disable iff (rst_i) ack_i |=> !ack_i)
		else $error("Wishbone ack high for two cycles in a row");

	ce_gap: assert property (@(posedge clk_i) disable iff (rst_i) $rose(ce_n_i) |=> ce_n_i)
		else $error("QSPI chip enable high for less than two cycles between bursts");

	ce_len: assert property (@(posedge clk_i) disable iff (rst_i)
		$rose(ce_n_i) |-> (low_cnt == burst_cycles))
		else $error("QSPI burst length differs from the expected cycle count");

endmodule

// Ack rule on the host side, CE rules on the writer
bind wb_status_regs cam_fb_assert u_ack_assert (
	.clk_i  (WBs_CLK_i),
	.rst_i  (WBs_RST_i),
	.ack_i  (wbs_ack_o),
	.ce_n_i (1'b1)
);

bind qspi_burst_writer cam_fb_assert u_ce_assert (
	.clk_i  (WBs_CLK_i),
	.rst_i  (WBs_RST_i),
	.ack_i  (1'b0),
	.ce_n_i (qspi_ce_n_o)
);

//--- source/cam_fb_top.sv
`timescale 1ns/1ps

module cam_fb_top (
	input  logic                  WBs_CLK_i,
	input  logic                  WBs_RST_i,
	input  logic                  wbs_status_cyc_i,
	input  logic                  wbs_stb_i,
	input  logic                  wbs_we_i,
	input  cam_fb_pkg::fb_word_t  wbs_dat_i,
	output logic                  wbs_ack_o,
	output cam_fb_pkg::fb_word_t  wbs_status_dat_o,
	input  logic                  cam_vsync_i,
	input  logic                  cam_href_i,
	input  cam_fb_pkg::cam_byte_t cam_dat_i,
	output logic                  qspi_ce_n_o,
	output logic [3:0]            qspi_dat_o
);

	logic                 drain_en;   // Host mode says write
	logic                 cam_bank;   // Bank the camera fills
	logic                 fb_wr_en;
	cam_fb_pkg::fb_addr_t fb_wr_addr;
	cam_fb_pkg::fb_word_t fb_wr_data;
	logic                 fb_rd_en;
	cam_fb_pkg::fb_addr_t fb_rd_addr;
	cam_fb_pkg::fb_word_t fb_rd_data;

	// --------------------
	// Host side
	// --------------------
	wb_status_regs u_regs (
		.WBs_CLK_i        (WBs_CLK_i),
		.WBs_RST_i        (WBs_RST_i),
		.wbs_status_cyc_i (wbs_status_cyc_i),
		.wbs_stb_i        (wbs_stb_i),
		.wbs_we_i         (wbs_we_i),
		.wbs_dat_i        (wbs_dat_i),
		.cam_vsync_i      (cam_vsync_i),
		.cam_bank_i       (cam_bank),
		.wbs_ack_o        (wbs_ack_o),
		.wbs_status_dat_o (wbs_status_dat_o),
		.drain_en_o       (drain_en)
	);

	// --------------------
	// Camera into buffer
	// --------------------
	cam_word_packer u_packer (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.cam_href_i   (cam_href_i),
		.cam_vsync_i  (cam_vsync_i),
		.cam_dat_i    (cam_dat_i),
		.fb_wr_en_o   (fb_wr_en),
		.fb_wr_addr_o (fb_wr_addr),
		.fb_wr_data_o (fb_wr_data),
		.cam_bank_o   (cam_bank)
	);

	frame_buffer u_fb (
		.WBs_CLK_i (WBs_CLK_i),
		.wr_en_i   (fb_wr_en),
		.wr_addr_i (fb_wr_addr),
		.wr_data_i (fb_wr_data),
		.rd_en_i   (fb_rd_en),
		.rd_addr_i (fb_rd_addr),
		.rd_data_o (fb_rd_data)
	);

	// Buffer out to the SRAM
	qspi_burst_writer u_qspi (
		.WBs_CLK_i    (WBs_CLK_i),
		.WBs_RST_i    (WBs_RST_i),
		.drain_en_i   (drain_en),
		.cam_bank_i   (cam_bank),
		.fb_rd_en_o   (fb_rd_en),
		.fb_rd_addr_o (fb_rd_addr),
		.fb_rd_data_i (fb_rd_data),
		.qspi_ce_n_o  (qspi_ce_n_o),
		.qspi_dat_o   (qspi_dat_o)
	);

endmodule

//--- source/qspi_burst_writer.sv
`timescale 1ns/1ps
`include "cam_fb_consts.svh"

module qspi_burst_writer (
	input  logic                 WBs_CLK_i,
	input  logic                 WBs_RST_i,
	input  logic                 drain_en_i,
	input  logic                 cam_bank_i,
	output logic                 fb_rd_en_o,
	output cam_fb_pkg::fb_addr_t fb_rd_addr_o,
	input  cam_fb_pkg::fb_word_t fb_rd_data_i,
	output logic                 qspi_ce_n_o,
	output logic [3:0]           qspi_dat_o
);

	localparam int word_cnt_w = $clog2(`QSPI_BURST_WORDS);
	localparam logic [word_cnt_w-1:0] last_word = word_cnt_w'(`QSPI_BURST_WORDS - 1);
	localparam logic [7:0] cmd_byte = `QSPI_CMD_WRITE;

	cam_fb_pkg::qspi_state_e state;
	logic [2:0]              step;       // Bit or nibble now on the pins
	logic [word_cnt_w-1:0]   word_cnt;   // Word within the burst
	cam_fb_pkg::fb_addr_t    rd_ptr;     // Next buffer word to fetch
	cam_fb_pkg::qspi_addr_t  burst_addr; // SRAM address of the current burst
	cam_fb_pkg::fb_word_t    data_sr;    // Remaining nibbles of the word
	logic                    mid_bank;   // Bank not yet fully drained
	logic                    launch;     // Drop CE and send the command
	logic                    load_word;  // Fetched word goes out next

	assign mid_bank = (rd_ptr[`FB_ADDR_W-2:0] != '0);

	// New bank only while the camera fills the other one
	assign launch = ((state == cam_fb_pkg::NEXT) && mid_bank) ||
		((state == cam_fb_pkg::WAIT_BANK) && drain_en_i &&
		(cam_bank_i != rd_ptr[`FB_ADDR_W-1]));

	assign load_word = ((state == cam_fb_pkg::ADDR) && (step == 3'd5)) ||
		((state == cam_fb_pkg::DATA) && (step == 3'd7));

	// Prefetch two cycles ahead of the first nibble of a word
	assign fb_rd_en_o = ((state == cam_fb_pkg::ADDR) && (step == 3'd4)) ||
		((state == cam_fb_pkg::DATA) && (step == 3'd6) && (word_cnt != last_word));
	assign fb_rd_addr_o = rd_ptr;

	// --------------------
	// Burst sequencer
	// --------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state       <= cam_fb_pkg::IDLE;
			step        <= '0;
			word_cnt    <= '0;
			rd_ptr      <= '0;
			burst_addr  <= `QSPI_START_ADDR;
			qspi_ce_n_o <= 1'b1;
			qspi_dat_o  <= 4'h0;
		end else if (launch) begin
			state       <= cam_fb_pkg::CMD;
			step        <= '0;
			word_cnt    <= '0;
			qspi_ce_n_o <= 1'b0;
			qspi_dat_o  <= {3'b000, cmd_byte[7]};               // Command MSB first, on DQ0
		end else begin
			if (fb_rd_en_o)
				rd_ptr <= rd_ptr + 1'b1;                        // Wraps over both banks
			case (state)
				cam_fb_pkg::IDLE: begin
					if (drain_en_i)
						state <= cam_fb_pkg::WAIT_BANK;
				end
				cam_fb_pkg::WAIT_BANK: begin
					if (!drain_en_i)
						state <= cam_fb_pkg::IDLE;              // Host stopped the drain
				end
				cam_fb_pkg::CMD: begin
					if (step == 3'd7) begin
						qspi_dat_o <= burst_addr[`QSPI_ADDR_W-1 -: 4];
						step       <= '0;
						state      <= cam_fb_pkg::ADDR;
					end else begin
						qspi_dat_o <= {3'b000, cmd_byte[3'd6 - step]};
						step       <= step + 1'b1;
					end
				end
				cam_fb_pkg::ADDR: begin
					if (step == 3'd5) begin
						qspi_dat_o <= fb_rd_data_i[`FB_WORD_W-1 -: 4];
						step       <= '0;
						state      <= cam_fb_pkg::DATA;
					end else begin
						qspi_dat_o <= burst_addr[4*(4-step) +: 4]; // Six nibbles, MSB first
						step       <= step + 1'b1;
					end
				end
				cam_fb_pkg::DATA: begin
					if (step == 3'd7 && word_cnt == last_word) begin
						qspi_ce_n_o <= 1'b1;                    // End of 1038-cycle burst
						qspi_dat_o  <= 4'h0;
						state       <= cam_fb_pkg::CE_GAP;
					end else if (step == 3'd7) begin
						qspi_dat_o <= fb_rd_data_i[`FB_WORD_W-1 -: 4];
						step       <= '0;
						word_cnt   <= word_cnt + 1'b1;
					end else begin
						qspi_dat_o <= data_sr[`FB_WORD_W-1 -: 4];
						step       <= step + 1'b1;
					end
				end
				cam_fb_pkg::CE_GAP: begin
					burst_addr <= burst_addr + cam_fb_pkg::qspi_addr_t'(`QSPI_BURST_BYTES);
					state      <= cam_fb_pkg::NEXT;
				end
				cam_fb_pkg::NEXT: begin
					// Bank boundary here, otherwise launch took over
					state <= drain_en_i ? cam_fb_pkg::WAIT_BANK : cam_fb_pkg::IDLE;
				end
				default: state <= cam_fb_pkg::IDLE;
			endcase
		end
	end

	// Nibble shifter for the word being sent
	always_ff @(posedge WBs_CLK_i) begin
		if (load_word)
			data_sr <= {fb_rd_data_i[`FB_WORD_W-5:0], 4'h0};
		else if (state == cam_fb_pkg::DATA)
			data_sr <= {data_sr[`FB_WORD_W-5:0], 4'h0};
	end

endmodule

//--- source/frame_buffer.sv
`timescale 1ns/1ps
`include "cam_fb_consts.svh"

module frame_buffer (
	input  logic                 WBs_CLK_i,
	input  logic                 wr_en_i,
	input  cam_fb_pkg::fb_addr_t wr_addr_i,
	input  cam_fb_pkg::fb_word_t wr_data_i,
	input  logic                 rd_en_i,
	input  cam_fb_pkg::fb_addr_t rd_addr_i,
	output cam_fb_pkg::fb_word_t rd_data_o
);

	// Bank 0 in the low half, bank 1 in the high half
	cam_fb_pkg::fb_word_t mem [2*`FB_BANK_WORDS];

	// Camera side
	always_ff @(posedge WBs_CLK_i) begin
		if (wr_en_i)
			mem[wr_addr_i] <= wr_data_i;
	end

	// QSPI side, data one cycle after the enable
	always_ff @(posedge WBs_CLK_i) begin
		if (rd_en_i)
			rd_data_o <= mem[rd_addr_i];      // Holds between reads
	end

endmodule

//--- source/cam_word_packer.sv
`timescale 1ns/1ps
`include "cam_fb_consts.svh"

module cam_word_packer (
	input  logic                  WBs_CLK_i,
	input  logic                  WBs_RST_i,
	input  logic                  cam_href_i,
	input  logic                  cam_vsync_i,
	input  cam_fb_pkg::cam_byte_t cam_dat_i,
	output logic                  fb_wr_en_o,
	output cam_fb_pkg::fb_addr_t  fb_wr_addr_o,
	output cam_fb_pkg::fb_word_t  fb_wr_data_o,
	output logic                  cam_bank_o
);

	logic                      byte_vld; // Pixel byte on this cycle
	cam_fb_pkg::packer_state_e state;
	logic [3*`CAM_BYTE_W-1:0]  held;     // First three bytes, oldest on top
	cam_fb_pkg::fb_addr_t      word_idx; // Next word slot in the buffer

	assign byte_vld = cam_href_i & cam_vsync_i;

	// --------------------
	// Byte count and write strobe
	// --------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			state      <= cam_fb_pkg::EMPTY;
			fb_wr_en_o <= 1'b0;
			word_idx   <= '0;
		end else begin
			fb_wr_en_o <= 1'b0;                  // Strobe lasts one cycle
			if (fb_wr_en_o)
				word_idx <= word_idx + 1'b1;     // Wraps at two banks
			if (byte_vld) begin
				case (state)
					cam_fb_pkg::EMPTY: state <= cam_fb_pkg::HAVE1;
					cam_fb_pkg::HAVE1: state <= cam_fb_pkg::HAVE2;
					cam_fb_pkg::HAVE2: state <= cam_fb_pkg::HAVE3;
					cam_fb_pkg::HAVE3: begin
						state      <= cam_fb_pkg::EMPTY;
						fb_wr_en_o <= 1'b1;      // Word complete
					end
					default: state <= cam_fb_pkg::EMPTY;
				endcase
			end
		end
	end

	// Byte shifter, first byte ends up as the MSB
	always_ff @(posedge WBs_CLK_i) begin
		if (byte_vld) begin
			held <= {held[2*`CAM_BYTE_W-1:0], cam_dat_i};
			if (state == cam_fb_pkg::HAVE3)
				fb_wr_data_o <= {held, cam_dat_i};
		end
	end

	assign fb_wr_addr_o = word_idx;
	assign cam_bank_o   = word_idx[`FB_ADDR_W-1]; // Moves once the last word of a bank lands

endmodule

//--- source/wb_status_regs.sv
`timescale 1ns/1ps
`include "cam_fb_consts.svh"

module wb_status_regs (
	input  logic                 WBs_CLK_i,
	input  logic                 WBs_RST_i,
	input  logic                 wbs_status_cyc_i,
	input  logic                 wbs_stb_i,
	input  logic                 wbs_we_i,
	input  cam_fb_pkg::fb_word_t wbs_dat_i,
	input  logic                 cam_vsync_i,
	input  logic                 cam_bank_i,
	output logic                 wbs_ack_o,
	output cam_fb_pkg::fb_word_t wbs_status_dat_o,
	output logic                 drain_en_o
);

	logic       wr_dcd; // Host write to the mode register
	logic [1:0] mode;   // Only the mode field is kept

	assign wr_dcd = wbs_status_cyc_i & wbs_stb_i & wbs_we_i & ~wbs_ack_o;

	// --------------------
	// Acknowledge and mode register
	// --------------------
	always_ff @(posedge WBs_CLK_i or posedge WBs_RST_i) begin
		if (WBs_RST_i) begin
			wbs_ack_o <= 1'b0;
			mode      <= 2'b00;                                     // Drain off after reset
		end else begin
			wbs_ack_o <= wbs_status_cyc_i & wbs_stb_i & ~wbs_ack_o; // One cycle, then drops
			if (wr_dcd)
				mode <= wbs_dat_i[1:0];                           // Same edge as the ack
		end
	end

	// Status word, live view of the camera side
	always_comb begin
		wbs_status_dat_o                    = '0;
		wbs_status_dat_o[`STATUS_VSYNC_BIT] = cam_vsync_i;
		wbs_status_dat_o[0]                 = cam_bank_i;   // Bank being filled now
	end

	assign drain_en_o = (mode == `STATUS_MODE_WRITE);     // Level to the QSPI writer

endmodule

//--- source/cam_fb_pkg.sv
package cam_fb_pkg;

`include "cam_fb_consts.svh"

	typedef logic [`CAM_BYTE_W-1:0]  cam_byte_t;  // Camera pixel byte
	typedef logic [`FB_WORD_W-1:0]   fb_word_t;   // Packed word, also the bus width
	typedef logic [`FB_ADDR_W-1:0]   fb_addr_t;   // Word index over both banks
	typedef logic [`QSPI_ADDR_W-1:0] qspi_addr_t; // SRAM byte address

	// Bytes held so far in the current word
	typedef enum logic [1:0] {
		EMPTY,
		HAVE1,
		HAVE2,
		HAVE3
	} packer_state_e;

	// Writer phases of one burst and the gaps between bursts
	typedef enum logic [2:0] {
		IDLE,
		WAIT_BANK,
		CMD,
		ADDR,
		DATA,
		CE_GAP,
		NEXT
	} qspi_state_e;

endpackage

//--- source/cam_fb_consts.svh
`ifndef CAM_FB_CONSTS_SVH
`define CAM_FB_CONSTS_SVH

// --------------------
// Camera and frame buffer
// --------------------
`define CAM_BYTE_W        8          // One camera byte
`define FB_WORD_W         32         // Four bytes per buffer word
`define FB_BANK_WORDS     512        // Words per bank
`define FB_ADDR_W         10         // Word index, top bit is the bank

// --------------------
// QSPI SRAM
// --------------------
`define QSPI_BURST_WORDS  128        // Words per burst
`define QSPI_BURST_BYTES  512        // SRAM address step per burst
`define QSPI_CMD_WRITE    8'h38      // Quad write
`define QSPI_START_ADDR   24'h000004 // First burst lands here
`define QSPI_ADDR_W       24

// Host status register
`define STATUS_MODE_WRITE 2'b10      // Mode field value, drain to SRAM
`define STATUS_VSYNC_BIT  8

`endif
